//--- common/arm_pipe_pkg.sv
package arm_pipe_pkg;

    //////////////////////////////
    // widths and types
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 4;

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // r15 reads back as the instruction address plus 8
    localparam reg_addr_t PC_REG         = 4'd15;
    localparam word_t     PC_STEP        = 32'd4;
    localparam word_t     PC_READ_OFFSET = 32'd8;

    localparam int IMM_DP_W  = 8;
    localparam int IMM_MEM_W = 12;

    //////////////////////////////
    // instruction field positions
    localparam int OP_POS    = 26;
    localparam int FUNCT_POS = 20;
    localparam int RN_POS    = 16;
    localparam int RD_POS    = 12;
    localparam int RM_POS    = 0;
    localparam int CMD_POS   = 21;
    localparam int I_BIT     = 25;
    localparam int L_BIT     = 20;

    // operand source selects for the execute muxes
    localparam logic [1:0] FWD_REG = 2'b00;
    localparam logic [1:0] FWD_WB  = 2'b01;
    localparam logic [1:0] FWD_MEM = 2'b10;

    typedef enum logic [1:0] {
        CLASS_DP  = 2'b00,
        CLASS_MEM = 2'b01
    } instr_class_e;

    // values follow the ARM cmd field
    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_SUB = 4'b0010,
        ALU_ADD = 4'b0100,
        ALU_ORR = 4'b1100
    } alu_op_e;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        logic      mem_write;
        logic      alu_src;
        alu_op_e   alu_op;
        reg_addr_t ra1;
        reg_addr_t ra2;
        reg_addr_t wa3;
        word_t     rd1;
        word_t     rd2;
        word_t     imm;
    } decode_bundle_t;

endpackage

//--- common/ex_mem_if.sv
`timescale 1ns/1ps

interface ex_mem_if;
    import arm_pipe_pkg::*;

    // control, all low for a bubble
    logic      reg_write;
    logic      mem_to_reg;
    logic      mem_write;

    // payload
    word_t     alu_out;
    word_t     write_data;
    reg_addr_t wa3;

    modport producer (
        output reg_write,
        output mem_to_reg,
        output mem_write,
        output alu_out,
        output write_data,
        output wa3
    );

    modport consumer (
        input reg_write,
        input mem_to_reg,
        input mem_write,
        input alu_out,
        input write_data,
        input wa3
    );

endinterface

//--- verilog/front_end.sv
`timescale 1ns/1ps

module front_end (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  arm_pipe_pkg::word_t instr,
    output arm_pipe_pkg::word_t pc,
    output arm_pipe_pkg::word_t instr_d,
    output arm_pipe_pkg::word_t pc_d
);
    import arm_pipe_pkg::*;

    // fetch address, held for the load-use bubble
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc + PC_STEP;
        end
    end

    //////////////////////////////
    // fetch to decode register
    // zero decodes as and r0, r0, r0
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_d <= '0;
            pc_d    <= '0;
        end else if (!stall) begin
            instr_d <= instr;
            pc_d    <= pc;
        end
    end

endmodule

//--- decode/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  arm_pipe_pkg::instr_class_e op,
    input  logic [5:0]                 funct,
    input  arm_pipe_pkg::reg_addr_t    rd,
    output logic                       reg_write,
    output logic                       mem_to_reg,
    output logic                       mem_write,
    output logic                       alu_src,
    output logic                       imm_mem,
    output arm_pipe_pkg::alu_op_e      alu_op
);
    import arm_pipe_pkg::*;

    logic [3:0] cmd;

    assign cmd = funct[CMD_POS-FUNCT_POS +: 4];

    always_comb begin
        reg_write  = 1'b0;
        mem_to_reg = 1'b0;
        mem_write  = 1'b0;
        alu_src    = 1'b0;
        imm_mem    = 1'b0;
        alu_op     = ALU_ADD;
        case (op)
            CLASS_DP: begin
                alu_src = funct[I_BIT-FUNCT_POS];
                case (cmd)
                    ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR: begin
                        alu_op    = alu_op_e'(cmd);
                        reg_write = 1'b1;
                    end
                    // other data-processing ops are not supported
                    default: reg_write = 1'b0;
                endcase
            end
            CLASS_MEM: begin
                // address is rn plus the 12-bit offset
                alu_src = 1'b1;
                imm_mem = 1'b1;
                if (funct[L_BIT-FUNCT_POS]) begin
                    reg_write  = 1'b1;
                    mem_to_reg = 1'b1;
                end else begin
                    mem_write = 1'b1;
                end
            end
            default: reg_write = 1'b0;
        endcase
        // r15 as destination writes nothing
        if (rd == PC_REG) begin
            reg_write = 1'b0;
        end
    end

endmodule

//--- decode/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    we,
    input  arm_pipe_pkg::reg_addr_t wa,
    input  arm_pipe_pkg::word_t     wd,
    input  arm_pipe_pkg::reg_addr_t ra1,
    input  arm_pipe_pkg::reg_addr_t ra2,
    input  arm_pipe_pkg::word_t     pc_value,
    output arm_pipe_pkg::word_t     rd1,
    output arm_pipe_pkg::word_t     rd2
);
    import arm_pipe_pkg::*;

    // r0 to r14, r15 is not stored
    word_t regs [0:PC_REG-1];

    function automatic word_t read_port(input reg_addr_t ra);
        if (ra == PC_REG) begin
            return pc_value;
        end else if (we && (ra == wa)) begin
            // write-through for same-cycle read
            return wd;
        end
        return regs[ra];
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < int'(PC_REG); i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != PC_REG)) begin
            regs[wa] <= wd;
        end
    end

    always_comb begin
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
    end

    // decode clears reg_write for r15, nothing downstream may set it again
    a_no_pc_write: assert property (@(posedge clk) disable iff (reset) we |-> (wa != PC_REG))
        else $error("reg_file: write to r15 reached writeback");

endmodule

//--- decode/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  arm_pipe_pkg::word_t            instr_d,
    input  arm_pipe_pkg::word_t            pc_d,
    input  logic                           reg_write_w,
    input  arm_pipe_pkg::reg_addr_t        wa3_w,
    input  arm_pipe_pkg::word_t            result_w,
    output arm_pipe_pkg::decode_bundle_t   bundle
);
    import arm_pipe_pkg::*;

    instr_class_e op;
    logic [5:0]   funct;
    reg_addr_t    rn;
    reg_addr_t    rd;
    reg_addr_t    rm;
    reg_addr_t    ra2;
    logic         reg_write;
    logic         mem_to_reg;
    logic         mem_write;
    logic         alu_src;
    logic         imm_mem;
    alu_op_e      alu_op;
    word_t        rd1;
    word_t        rd2;
    word_t        imm;
    word_t        pc_value;

    //////////////////////////////
    // field extraction
    assign op    = instr_class_e'(instr_d[OP_POS +: 2]);
    assign funct = instr_d[FUNCT_POS +: 6];
    assign rn    = instr_d[RN_POS +: REG_ADDR_W];
    assign rd    = instr_d[RD_POS +: REG_ADDR_W];
    assign rm    = instr_d[RM_POS +: REG_ADDR_W];

    // stores read rd as the data operand
    assign ra2 = imm_mem ? rd : rm;

    assign imm = imm_mem ? word_t'(instr_d[IMM_MEM_W-1:0])
                         : word_t'(instr_d[IMM_DP_W-1:0]);

    assign pc_value = pc_d + PC_READ_OFFSET;

    decoder decoder_u (
        .op         (op),
        .funct      (funct),
        .rd         (rd),
        .reg_write  (reg_write),
        .mem_to_reg (mem_to_reg),
        .mem_write  (mem_write),
        .alu_src    (alu_src),
        .imm_mem    (imm_mem),
        .alu_op     (alu_op)
    );

    reg_file reg_file_u (
        .clk      (clk),
        .reset    (reset),
        .we       (reg_write_w),
        .wa       (wa3_w),
        .wd       (result_w),
        .ra1      (rn),
        .ra2      (ra2),
        .pc_value (pc_value),
        .rd1      (rd1),
        .rd2      (rd2)
    );

    always_comb begin
        bundle.reg_write  = reg_write;
        bundle.mem_to_reg = mem_to_reg;
        bundle.mem_write  = mem_write;
        bundle.alu_src    = alu_src;
        bundle.alu_op     = alu_op;
        bundle.ra1        = rn;
        bundle.ra2        = ra2;
        bundle.wa3        = rd;
        bundle.rd1        = rd1;
        bundle.rd2        = rd2;
        bundle.imm        = imm;
    end

endmodule

//--- execute/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stall,
    input  arm_pipe_pkg::decode_bundle_t bundle,
    input  logic [1:0]                   forward_a,
    input  logic [1:0]                   forward_b,
    input  arm_pipe_pkg::word_t          alu_out_m,
    input  arm_pipe_pkg::word_t          result_w,
    output arm_pipe_pkg::reg_addr_t      ra1_e,
    output arm_pipe_pkg::reg_addr_t      ra2_e,
    output arm_pipe_pkg::reg_addr_t      wa3_e,
    output logic                         load_e,
    ex_mem_if.producer                   ex_mem
);
    import arm_pipe_pkg::*;

    decode_bundle_t bundle_e;
    decode_bundle_t bubble;
    word_t          src_a;
    word_t          src_b_reg;
    word_t          src_b;
    word_t          alu_result;

    function automatic word_t fwd_mux(input logic [1:0] sel, input word_t reg_val,
                                      input word_t m_val, input word_t w_val);
        case (sel)
            FWD_MEM: return m_val;
            FWD_WB:  return w_val;
            default: return reg_val;
        endcase
    endfunction

    // decode bundle with its control bits cleared
    always_comb begin
        bubble            = bundle;
        bubble.reg_write  = 1'b0;
        bubble.mem_to_reg = 1'b0;
        bubble.mem_write  = 1'b0;
        bubble.alu_src    = 1'b0;
    end

    //////////////////////////////
    // decode to execute register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bundle_e <= '0;
        end else begin
            bundle_e <= stall ? bubble : bundle;
        end
    end

    assign src_a     = fwd_mux(forward_a, bundle_e.rd1, alu_out_m, result_w);
    assign src_b_reg = fwd_mux(forward_b, bundle_e.rd2, alu_out_m, result_w);
    assign src_b     = bundle_e.alu_src ? bundle_e.imm : src_b_reg;

    always_comb begin
        case (bundle_e.alu_op)
            ALU_ADD: alu_result = src_a + src_b;
            ALU_SUB: alu_result = src_a - src_b;
            ALU_AND: alu_result = src_a & src_b;
            ALU_ORR: alu_result = src_a | src_b;
            default: alu_result = '0;
        endcase
    end

    assign ra1_e  = bundle_e.ra1;
    assign ra2_e  = bundle_e.ra2;
    assign wa3_e  = bundle_e.wa3;
    assign load_e = bundle_e.reg_write & bundle_e.mem_to_reg;

    // towards the memory stage, store data is the forwarded rd
    assign ex_mem.reg_write  = bundle_e.reg_write;
    assign ex_mem.mem_to_reg = bundle_e.mem_to_reg;
    assign ex_mem.mem_write  = bundle_e.mem_write;
    assign ex_mem.alu_out    = alu_result;
    assign ex_mem.write_data = src_b_reg;
    assign ex_mem.wa3        = bundle_e.wa3;

    // hazard unit only issues the three defined selects
    a_fwd_sel: assert property (@(posedge clk) disable iff (reset)
        (forward_a != 2'b11) && (forward_b != 2'b11))
        else $error("execute_stage: undefined forwarding select");

endmodule

//--- verilog/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  arm_pipe_pkg::word_t     read_data,
    ex_mem_if.consumer              ex_mem,
    output arm_pipe_pkg::word_t     data_addr,
    output arm_pipe_pkg::word_t     write_data,
    output logic                    mem_write,
    output arm_pipe_pkg::word_t     alu_out_m,
    output arm_pipe_pkg::reg_addr_t wa3_m,
    output logic                    reg_write_m,
    output arm_pipe_pkg::word_t     result_w,
    output arm_pipe_pkg::reg_addr_t wa3_w,
    output logic                    reg_write_w
);
    import arm_pipe_pkg::*;

    logic  mem_to_reg_m;
    logic  mem_to_reg_w;
    word_t read_data_w;
    word_t alu_out_w;

    //////////////////////////////
    // control bits for memory and writeback
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_write_m  <= 1'b0;
            mem_to_reg_m <= 1'b0;
            mem_write    <= 1'b0;
            reg_write_w  <= 1'b0;
            mem_to_reg_w <= 1'b0;
        end else begin
            reg_write_m  <= ex_mem.reg_write;
            mem_to_reg_m <= ex_mem.mem_to_reg;
            mem_write    <= ex_mem.mem_write;
            reg_write_w  <= reg_write_m;
            mem_to_reg_w <= mem_to_reg_m;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        alu_out_m   <= ex_mem.alu_out;
        write_data  <= ex_mem.write_data;
        wa3_m       <= ex_mem.wa3;
        read_data_w <= read_data;
        alu_out_w   <= alu_out_m;
        wa3_w       <= wa3_m;
    end

    assign data_addr = alu_out_m;
    assign result_w  = mem_to_reg_w ? read_data_w : alu_out_w;

endmodule

//--- verilog/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  arm_pipe_pkg::reg_addr_t ra1_d,
    input  arm_pipe_pkg::reg_addr_t ra2_d,
    input  arm_pipe_pkg::reg_addr_t ra1_e,
    input  arm_pipe_pkg::reg_addr_t ra2_e,
    input  arm_pipe_pkg::reg_addr_t wa3_e,
    input  logic                    load_e,
    input  arm_pipe_pkg::reg_addr_t wa3_m,
    input  arm_pipe_pkg::reg_addr_t wa3_w,
    input  logic                    reg_write_m,
    input  logic                    reg_write_w,
    output logic                    stall,
    output logic [1:0]              forward_a,
    output logic [1:0]              forward_b
);
    import arm_pipe_pkg::*;

    // memory stage wins over writeback
    function automatic logic [1:0] fwd_sel(input reg_addr_t ra);
        if (reg_write_m && (wa3_m == ra)) begin
            return FWD_MEM;
        end else if (reg_write_w && (wa3_w == ra)) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        forward_a = fwd_sel(ra1_e);
        forward_b = fwd_sel(ra2_e);
    end

    // load in execute feeding decode, checked whether or not the operand is used
    assign stall = load_e && ((ra1_d == wa3_e) || (ra2_d == wa3_e));

endmodule

//--- verilog/arm_pipe_core.sv
`timescale 1ns/1ps

module arm_pipe_core (
    input  logic                clk,
    input  logic                reset,
    input  arm_pipe_pkg::word_t instr,
    output arm_pipe_pkg::word_t pc,
    input  arm_pipe_pkg::word_t read_data,
    output arm_pipe_pkg::word_t data_addr,
    output arm_pipe_pkg::word_t write_data,
    output logic                mem_write
);
    import arm_pipe_pkg::*;

    word_t          instr_d;
    word_t          pc_d;
    decode_bundle_t bundle_d;
    logic           stall;
    logic [1:0]     forward_a;
    logic [1:0]     forward_b;
    reg_addr_t      ra1_e;
    reg_addr_t      ra2_e;
    reg_addr_t      wa3_e;
    logic           load_e;
    word_t          alu_out_m;
    reg_addr_t      wa3_m;
    logic           reg_write_m;
    word_t          result_w;
    reg_addr_t      wa3_w;
    logic           reg_write_w;

    ex_mem_if ex_mem_bus ();

    front_end front_end_u (
        .clk (clk), .reset (reset), .stall (stall),
        .instr (instr), .pc (pc), .instr_d (instr_d), .pc_d (pc_d)
    );

    decode_stage decode_stage_u (
        .clk (clk), .reset (reset), .instr_d (instr_d), .pc_d (pc_d),
        .reg_write_w (reg_write_w), .wa3_w (wa3_w), .result_w (result_w),
        .bundle (bundle_d)
    );

    execute_stage execute_stage_u (
        .clk (clk), .reset (reset), .stall (stall), .bundle (bundle_d),
        .forward_a (forward_a), .forward_b (forward_b),
        .alu_out_m (alu_out_m), .result_w (result_w),
        .ra1_e (ra1_e), .ra2_e (ra2_e), .wa3_e (wa3_e), .load_e (load_e),
        .ex_mem (ex_mem_bus.producer)
    );

    mem_wb_stage mem_wb_stage_u (
        .clk (clk), .reset (reset), .read_data (read_data),
        .ex_mem (ex_mem_bus.consumer),
        .data_addr (data_addr), .write_data (write_data), .mem_write (mem_write),
        .alu_out_m (alu_out_m), .wa3_m (wa3_m), .reg_write_m (reg_write_m),
        .result_w (result_w), .wa3_w (wa3_w), .reg_write_w (reg_write_w)
    );

    hazard_unit hazard_unit_u (
        .ra1_d (bundle_d.ra1), .ra2_d (bundle_d.ra2),
        .ra1_e (ra1_e), .ra2_e (ra2_e), .wa3_e (wa3_e), .load_e (load_e),
        .wa3_m (wa3_m), .wa3_w (wa3_w),
        .reg_write_m (reg_write_m), .reg_write_w (reg_write_w),
        .stall (stall), .forward_a (forward_a), .forward_b (forward_b)
    );

endmodule

//--- verif/tb_arm_pipe_core.sv
`timescale 1ns/1ps

module tb_arm_pipe_core;
    import arm_pipe_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int IMEM_DEPTH   = 64;
    localparam int DMEM_DEPTH   = 1024;
    localparam int MAX_PROG     = 24;
    localparam int RUN_EXTRA    = 12;
    localparam int N_RUNS       = 9;
    localparam int WATCHDOG_CYCLES = N_RUNS * (MAX_PROG + RUN_EXTRA + RESET_CYCLES + 3) + 100;

    // cmd field codes
    localparam logic [3:0] C_AND = 4'b0000;
    localparam logic [3:0] C_SUB = 4'b0010;
    localparam logic [3:0] C_ADD = 4'b0100;
    localparam logic [3:0] C_ORR = 4'b1100;

    logic  clk;
    logic  reset;
    word_t instr;
    word_t pc;
    word_t read_data;
    word_t data_addr;
    word_t write_data;
    logic  mem_write;

    word_t imem [0:IMEM_DEPTH-1];
    word_t dmem [0:DMEM_DEPTH-1];
    word_t ref_mem [0:DMEM_DEPTH-1];
    word_t ref_r [0:14];
    logic  clear_dmem;
    int    cyc;
    int    errors;
    int    seed;

    word_t prog[$];
    word_t st_addr[$];
    word_t st_data[$];
    int    st_cyc[$];
    word_t pc_log[$];
    word_t exp_addr[$];
    word_t exp_data[$];

    arm_pipe_core i_dut (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .pc         (pc),
        .read_data  (read_data),
        .data_addr  (data_addr),
        .write_data (write_data),
        .mem_write  (mem_write)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    //////////////////////////////
    // memory models
    assign instr     = imem[pc[7:2]];
    assign read_data = dmem[data_addr[11:2]];

    function automatic word_t fill_word(input int i);
        return 32'hd000_0000 | (i << 2);
    endfunction

    // cycle 0 is the first cycle after reset release
    always @(posedge clk) begin
        if (reset) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    always @(posedge clk) begin
        if (clear_dmem) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= fill_word(i);
            end
            st_addr.delete();
            st_data.delete();
            st_cyc.delete();
            pc_log.delete();
        end else if (!reset) begin
            pc_log.push_back(pc);
            if (mem_write) begin
                dmem[data_addr[11:2]] <= write_data;
                st_addr.push_back(data_addr);
                st_data.push_back(write_data);
                st_cyc.push_back(cyc);
            end
        end
    end

    //////////////////////////////
    // helpers
    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [7:0] rand_byte();
        return 8'($random(seed));
    endfunction

    function automatic word_t enc_dp(input logic [3:0] cmd, input logic imm,
                                     input logic [3:0] rd, input logic [3:0] rn,
                                     input logic [7:0] op2);
        return {4'hE, 2'b00, imm, cmd, 1'b0, rn, rd, 4'h0, op2};
    endfunction

    function automatic word_t enc_mem(input logic load, input logic [3:0] rd,
                                      input logic [3:0] rn, input logic [11:0] off);
        return {4'hE, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, off};
    endfunction

    // r15 reads as the instruction address plus 8
    function automatic word_t reg_value(input logic [3:0] r, input word_t addr);
        if (r == 4'd15) begin
            return addr + 32'd8;
        end
        return ref_r[r];
    endfunction

    task automatic add_padding(input int n);
        for (int i = 0; i < n; i++) begin
            prog.push_back(enc_dp(C_ADD, 1'b1, 4'd9, 4'd0, 8'h01));
        end
    endtask

    // one instruction at a time, in program order
    task automatic run_reference();
        word_t ins;
        word_t a;
        word_t b;
        word_t res;
        word_t addr;
        logic [3:0] rd;
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            ref_mem[i] = fill_word(i);
        end
        for (int r = 0; r < 15; r++) begin
            ref_r[r] = '0;
        end
        exp_addr.delete();
        exp_data.delete();
        foreach (prog[i]) begin
            ins = prog[i];
            rd  = ins[15:12];
            res = '0;
            a   = reg_value(ins[19:16], 32'(i * 4));
            if (ins[27:26] == 2'b00) begin
                b = ins[25] ? {24'b0, ins[7:0]} : reg_value(ins[3:0], 32'(i * 4));
                case (ins[24:21])
                    C_ADD: res = a + b;
                    C_SUB: res = a - b;
                    C_AND: res = a & b;
                    C_ORR: res = a | b;
                    default: rd = 4'd15;
                endcase
                if (rd != 4'd15) begin
                    ref_r[rd] = res;
                end
            end else begin
                addr = a + {20'b0, ins[11:0]};
                if (ins[20]) begin
                    if (rd != 4'd15) begin
                        ref_r[rd] = ref_mem[addr[11:2]];
                    end
                end else begin
                    ref_mem[addr[11:2]] = reg_value(rd, 32'(i * 4));
                    exp_addr.push_back(addr);
                    exp_data.push_back(ref_mem[addr[11:2]]);
                end
            end
        end
    endtask

    // load program, reset, run, then compare stores and memory
    task automatic run_program();
        int n;
        n = prog.size();
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            imem[i] = (i < n) ? prog[i] : '0;
        end
        run_reference();
        @(posedge clk);
        reset      <= 1'b1;
        clear_dmem <= 1'b1;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compare_word("pc", pc, 32'd0);
            compare_word("mem_write", 32'(mem_write), 32'd0);
        end
        @(posedge clk);
        reset      <= 1'b0;
        clear_dmem <= 1'b0;
        repeat (n + RUN_EXTRA) @(posedge clk);
        @(negedge clk);
        compare_word("store count", 32'(st_addr.size()), 32'(exp_addr.size()));
        for (int i = 0; i < st_addr.size() && i < exp_addr.size(); i++) begin
            compare_word("data_addr", st_addr[i], exp_addr[i]);
            compare_word("write_data", st_data[i], exp_data[i]);
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            compare_word("dmem", dmem[i], ref_mem[i]);
        end
    endtask

    //////////////////////////////
    // directed tests
    task automatic reset_and_fetch();
        prog.delete();
        for (int k = 1; k < 9; k++) begin
            prog.push_back(enc_dp(C_ADD, 1'b1, 4'(k), 4'd0, rand_byte()));
        end
        run_program();
        compare_word("pc after reset", pc_log[0], 32'd0);
        for (int i = 1; i < pc_log.size(); i++) begin
            compare_word("pc", pc_log[i], 32'(i * 4));
        end
    endtask

    task automatic alu_ops();
        logic [3:0] cmds [4];
        cmds = '{C_ADD, C_SUB, C_AND, C_ORR};
        prog.delete();
        for (int k = 0; k < 4; k++) begin
            prog.push_back(enc_dp(C_ADD, 1'b1, 4'd1, 4'd0, rand_byte()));
            prog.push_back(enc_dp(C_ADD, 1'b1, 4'd2, 4'd0, rand_byte()));
            prog.push_back(enc_dp(cmds[k], 1'b1, 4'd3, 4'd1, rand_byte()));
            prog.push_back(enc_mem(1'b0, 4'd3, 4'd0, 12'(12'h100 + k * 8)));
            // register operand r2
            prog.push_back(enc_dp(cmds[k], 1'b0, 4'd4, 4'd1, 8'h02));
            prog.push_back(enc_mem(1'b0, 4'd4, 4'd0, 12'(12'h104 + k * 8)));
        end
        run_program();
    endtask

    // gap 0 and 1 forward from memory and writeback, gap 2 hits the write-through read
    task automatic forwarding_chains();
        for (int gap = 0; gap < 3; gap++) begin
            prog.delete();
            prog.push_back(enc_dp(C_ADD, 1'b1, 4'd5, 4'd0, rand_byte()));
            add_padding(gap);
            prog.push_back(enc_dp(C_ADD, 1'b1, 4'd6, 4'd5, rand_byte()));
            add_padding(gap);
            prog.push_back(enc_dp(C_SUB, 1'b0, 4'd7, 4'd6, 8'h05));
            add_padding(gap);
            prog.push_back(enc_dp(C_ORR, 1'b0, 4'd8, 4'd7, 8'h06));
            add_padding(gap);
            prog.push_back(enc_mem(1'b0, 4'd8, 4'd0, 12'h024));
            prog.push_back(enc_mem(1'b0, 4'd7, 4'd0, 12'h020));
            run_program();
        end
    endtask

    task automatic load_store_round_trip();
        logic [11:0] off;
        off = 12'($random(seed)) & 12'hffc;
        prog.delete();
        prog.push_back(enc_dp(C_ADD, 1'b1, 4'd1, 4'd0, rand_byte()));
        prog.push_back(enc_dp(C_ADD, 1'b0, 4'd1, 4'd1, 8'h01));
        // word-aligned base in r3
        prog.push_back(enc_dp(C_ADD, 1'b1, 4'd3, 4'd0, rand_byte() & 8'hfc));
        prog.push_back(enc_mem(1'b0, 4'd1, 4'd3, off));
        prog.push_back(enc_mem(1'b1, 4'd2, 4'd3, off));
        prog.push_back(enc_dp(C_ADD, 1'b1, 4'd9, 4'd0, 8'h03));
        prog.push_back(enc_mem(1'b0, 4'd2, 4'd0, 12'h040));
        run_program();
    endtask

    task automatic load_use_stall(input int gap);
        int repeats;
        int store_idx;
        word_t repeated_pc;
        prog.delete();
        prog.push_back(enc_dp(C_ADD, 1'b1, 4'd1, 4'd0, rand_byte()));
        prog.push_back(enc_mem(1'b0, 4'd1, 4'd0, 12'h080));
        prog.push_back(enc_mem(1'b1, 4'd2, 4'd0, 12'h080));
        add_padding(gap);
        prog.push_back(enc_dp(C_ADD, 1'b1, 4'd3, 4'd2, 8'h01));
        prog.push_back(enc_mem(1'b0, 4'd3, 4'd0, 12'h084));
        store_idx = prog.size() - 1;
        run_program();
        repeats     = 0;
        repeated_pc = '0;
        for (int i = 1; i < pc_log.size(); i++) begin
            if (pc_log[i] == pc_log[i-1]) begin
                repeats++;
                repeated_pc = pc_log[i];
            end
        end
        compare_word("pc repeats", 32'(repeats), (gap == 0) ? 32'd1 : 32'd0);
        if (gap == 0) begin
            // held fetch is the instruction after the dependent one
            compare_word("held pc", repeated_pc, 32'd16);
        end
        if (st_cyc.size() == 2) begin
            compare_word("store cycle", 32'(st_cyc[1]),
                         32'(store_idx + 3 + ((gap == 0) ? 1 : 0)));
        end else begin
            errors++;
            $display("load-use run did not produce two stores");
        end
    endtask

    task automatic pc_register_read();
        prog.delete();
        prog.push_back(enc_dp(C_ADD, 1'b1, 4'd1, 4'd0, 8'h11));
        prog.push_back(enc_dp(C_ADD, 1'b1, 4'd2, 4'd0, 8'h22));
        prog.push_back(enc_dp(C_ADD, 1'b1, 4'd3, 4'd15, 8'h00));
        prog.push_back(enc_mem(1'b0, 4'd3, 4'd0, 12'h200));
        // r15 destinations change nothing
        prog.push_back(enc_dp(C_ADD, 1'b1, 4'd15, 4'd1, 8'h05));
        prog.push_back(enc_dp(C_SUB, 1'b0, 4'd15, 4'd2, 8'h01));
        prog.push_back(enc_mem(1'b1, 4'd15, 4'd0, 12'h200));
        for (int k = 1; k < 15; k++) begin
            prog.push_back(enc_mem(1'b0, 4'(k), 4'd0, 12'(12'h300 + k * 4)));
        end
        run_program();
        if (st_data.size() > 0) begin
            compare_word("r15 read", st_data[0], 32'd16);
        end
    endtask

    //////////////////////////////
    // main sequence and watchdog
    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        clear_dmem = 1'b1;
        errors     = 0;
        seed       = 32'he413_7f18;
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            imem[i] = '0;
        end
        reset_and_fetch();
        alu_ops();
        forwarding_chains();
        load_store_round_trip();
        load_use_stall(0);
        load_use_stall(1);
        pc_register_read();
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- arm_pipe_core.f
common/arm_pipe_pkg.sv
common/ex_mem_if.sv
verilog/front_end.sv
decode/decoder.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/hazard_unit.sv
verilog/arm_pipe_core.sv
verif/tb_arm_pipe_core.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the core testbench

LOG=sim.log

verilator --binary --timing --assert --top-module tb_arm_pipe_core \
    -f arm_pipe_core.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "test failed"
    exit 1
fi
echo "test passed"
exit 0
